// File: rtl/i2c_pkg.sv
////////////////////////////////////////////////////////////////////////////
// I2C master shared definitions
// Register map, bit positions and the types between the controller blocks
////////////////////////////////////////////////////////////////////////////

package i2c_pkg;

  localparam int ADR_W = 3;
  localparam int DAT_W = 8;

  // Wishbone register addresses
  localparam logic [ADR_W-1:0] REG_PRER_LO = 3'd0;
  localparam logic [ADR_W-1:0] REG_PRER_HI = 3'd1;
  localparam logic [ADR_W-1:0] REG_CTR     = 3'd2;
  localparam logic [ADR_W-1:0] REG_TXR_RXR = 3'd3;
  localparam logic [ADR_W-1:0] REG_CR_SR   = 3'd4;

  // Control register
  localparam int CTR_EN  = 7;
  localparam int CTR_IEN = 6;
  localparam logic [DAT_W-1:0] CTR_WR_MASK = 8'hC0;

  // Command register
  localparam int CR_STA  = 7;
  localparam int CR_STO  = 6;
  localparam int CR_RD   = 5;
  localparam int CR_WR   = 4;
  localparam int CR_ACK  = 3;
  localparam int CR_IACK = 0;

  // Status register
  localparam int SR_RXACK = 7;
  localparam int SR_BUSY  = 6;
  localparam int SR_TIP   = 1;
  localparam int SR_IF    = 0;

  localparam logic [15:0] PRER_RESET = 16'hFFFF;

  // One byte command from the register block
  typedef struct packed {
    logic             sta;
    logic             sto;
    logic             rd;
    logic             wr;
    logic             ack;
    logic [DAT_W-1:0] txd;
  } byte_cmd_t;

  // Result of a byte command
  typedef struct packed {
    logic             done;
    logic             rxack;
    logic             busy;
    logic [DAT_W-1:0] rxd;
  } byte_stat_t;

  typedef enum logic [2:0] {
    BIT_IDLE,
    BIT_START,
    BIT_STOP,
    BIT_WRITE,
    BIT_READ
  } bit_cmd_e;

  typedef struct packed {
    bit_cmd_e cmd;
    logic     din;
  } bit_req_t;

endpackage

// File: rtl/i2c_wb_regs.sv
////////////////////////////////////////////////////////////////////////////
// I2C master Wishbone register block
// Prescale, control, data and command registers, status and interrupt
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module i2c_wb_regs import i2c_pkg::*; (
  input  logic             wb_clk_i,
  input  logic             arst_i,
  input  logic [ADR_W-1:0] wb_adr_i,
  input  logic [DAT_W-1:0] wb_dat_i,
  input  logic             wb_we_i,
  input  logic             wb_stb_i,
  input  logic             wb_cyc_i,
  output logic [DAT_W-1:0] wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_inta_o,
  output logic [15:0]      prescale_o,
  output logic             en_o,
  output byte_cmd_t        cmd_o,
  input  byte_stat_t       stat_i
);

  logic [15:0]      prer;
  logic [DAT_W-1:0] ctr;
  logic [DAT_W-1:0] txr;
  logic [DAT_W-1:0] rxr;
  logic [DAT_W-1:0] sr;
  logic             sta_q;
  logic             sto_q;
  logic             rd_q;
  logic             wr_q;
  logic             ack_q;
  logic             iack_q;
  logic             if_flag;
  logic             tip;
  logic             req;
  logic             wr_en;

  // New request while ack is still low
  assign req   = wb_cyc_i && wb_stb_i && !wb_ack_o;
  assign wr_en = req && wb_we_i;

  // A transfer is in progress while any command bit is pending
  assign tip = sta_q || sto_q || rd_q || wr_q;

  always_comb begin
    sr           = '0;
    sr[SR_RXACK] = stat_i.rxack;
    sr[SR_BUSY]  = stat_i.busy;
    sr[SR_TIP]   = tip;
    sr[SR_IF]    = if_flag;
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      wb_ack_o  <= 1'b0;
      prer      <= PRER_RESET;
      ctr       <= '0;
      rxr       <= '0;
      sta_q     <= 1'b0;
      sto_q     <= 1'b0;
      rd_q      <= 1'b0;
      wr_q      <= 1'b0;
      iack_q    <= 1'b0;
      if_flag   <= 1'b0;
      wb_inta_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
      if (wr_en && !ctr[CTR_EN] && (wb_adr_i == REG_PRER_LO)) begin
        prer[7:0] <= wb_dat_i;
      end
      if (wr_en && !ctr[CTR_EN] && (wb_adr_i == REG_PRER_HI)) begin
        prer[15:8] <= wb_dat_i;
      end
      if (wr_en && (wb_adr_i == REG_CTR)) begin
        ctr <= wb_dat_i & CTR_WR_MASK;
      end

      // Command bits drop when the byte finishes or the core is disabled
      if (stat_i.done || !ctr[CTR_EN]) begin
        sta_q <= 1'b0;
        sto_q <= 1'b0;
        rd_q  <= 1'b0;
        wr_q  <= 1'b0;
      end else if (wr_en && (wb_adr_i == REG_CR_SR) && !tip) begin
        sta_q <= wb_dat_i[CR_STA];
        sto_q <= wb_dat_i[CR_STO];
        rd_q  <= wb_dat_i[CR_RD];
        wr_q  <= wb_dat_i[CR_WR];
      end
      iack_q <= wr_en && (wb_adr_i == REG_CR_SR) && wb_dat_i[CR_IACK];

      if (stat_i.done) begin
        rxr     <= stat_i.rxd;
        if_flag <= 1'b1;
      end else if (iack_q) begin
        if_flag <= 1'b0;
      end
      wb_inta_o <= ctr[CTR_IEN] && if_flag;
    end
  end

  // Data registers and read data
  always_ff @(posedge wb_clk_i) begin
    if (wr_en && (wb_adr_i == REG_TXR_RXR)) begin
      txr <= wb_dat_i;
    end
    if (wr_en && (wb_adr_i == REG_CR_SR) && !tip) begin
      ack_q <= wb_dat_i[CR_ACK];
    end
    if (req) begin
      case (wb_adr_i)
        REG_PRER_LO: wb_dat_o <= prer[7:0];
        REG_PRER_HI: wb_dat_o <= prer[15:8];
        REG_CTR:     wb_dat_o <= ctr;
        REG_TXR_RXR: wb_dat_o <= rxr;
        REG_CR_SR:   wb_dat_o <= sr;
        default:     wb_dat_o <= '0;
      endcase
    end
  end

  assign prescale_o = prer;
  assign en_o       = ctr[CTR_EN];
  assign cmd_o.sta  = sta_q;
  assign cmd_o.sto  = sto_q;
  assign cmd_o.rd   = rd_q;
  assign cmd_o.wr   = wr_q;
  assign cmd_o.ack  = ack_q;
  assign cmd_o.txd  = txr;

endmodule

// File: rtl/i2c_byte_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// I2C byte controller
// Sequences START, eight data bits, acknowledge and STOP per command
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module i2c_byte_ctrl import i2c_pkg::*; (
  input  logic       wb_clk_i,
  input  logic       arst_i,
  input  logic       en_i,
  input  byte_cmd_t  cmd_i,
  output byte_stat_t stat_o,
  output bit_req_t   bit_req_o,
  input  logic       bit_done_i,
  input  logic       bit_dout_i
);

  localparam int CNT_W = $clog2(DAT_W);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_ACK,
    ST_STOP
  } state_e;

  state_e           state;
  logic [DAT_W-1:0] shreg;
  logic [CNT_W-1:0] bit_cnt;
  logic             rxack_q;
  logic             busy_q;
  logic             go;
  logic             xfer;
  logic             done;

  assign xfer = cmd_i.rd || cmd_i.wr;
  assign go   = cmd_i.sta || cmd_i.sto || xfer;

  // Done comes straight from the last bit so the command clears in step
  always_comb begin
    done = 1'b0;
    if (bit_done_i) begin
      case (state)
        ST_START: done = !xfer && !cmd_i.sto;
        ST_ACK:   done = !cmd_i.sto;
        ST_STOP:  done = 1'b1;
        default:  done = 1'b0;
      endcase
    end
  end

  always_comb begin
    bit_req_o.cmd = BIT_IDLE;
    bit_req_o.din = 1'b1;
    case (state)
      ST_START: bit_req_o.cmd = BIT_START;
      ST_DATA: begin
        bit_req_o.cmd = cmd_i.wr ? BIT_WRITE : BIT_READ;
        bit_req_o.din = cmd_i.wr ? shreg[DAT_W-1] : 1'b1;
      end
      // Slave acks a write, master acks a read
      ST_ACK: begin
        bit_req_o.cmd = cmd_i.wr ? BIT_READ : BIT_WRITE;
        bit_req_o.din = cmd_i.wr ? 1'b1 : cmd_i.ack;
      end
      ST_STOP:  bit_req_o.cmd = BIT_STOP;
      default:  bit_req_o.cmd = BIT_IDLE;
    endcase
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      rxack_q <= 1'b0;
      busy_q  <= 1'b0;
    end else if (!en_i) begin
      state  <= ST_IDLE;
      busy_q <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (go) begin
            bit_cnt <= CNT_W'(DAT_W - 1);
            if (cmd_i.sta) begin
              state <= ST_START;
            end else if (xfer) begin
              state <= ST_DATA;
            end else begin
              state <= ST_STOP;
            end
          end
        end
        ST_START: begin
          if (bit_done_i) begin
            busy_q <= 1'b1;
            if (xfer) begin
              state <= ST_DATA;
            end else if (cmd_i.sto) begin
              state <= ST_STOP;
            end else begin
              state <= ST_IDLE;
            end
          end
        end
        ST_DATA: begin
          if (bit_done_i) begin
            if (bit_cnt == '0) begin
              state <= ST_ACK;
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
            end
          end
        end
        ST_ACK: begin
          if (bit_done_i) begin
            if (cmd_i.wr) begin
              rxack_q <= bit_dout_i;
            end
            state <= cmd_i.sto ? ST_STOP : ST_IDLE;
          end
        end
        ST_STOP: begin
          if (bit_done_i) begin
            busy_q <= 1'b0;
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Shift out MSB first, shift in the sampled bit
  always_ff @(posedge wb_clk_i) begin
    if ((state == ST_IDLE) && go) begin
      shreg <= cmd_i.txd;
    end else if ((state == ST_DATA) && bit_done_i) begin
      shreg <= {shreg[DAT_W-2:0], bit_dout_i};
    end
  end

  assign stat_o.done  = done;
  assign stat_o.rxack = rxack_q;
  assign stat_o.busy  = busy_q;
  assign stat_o.rxd   = shreg;

endmodule

// File: rtl/i2c_bit_ctrl.sv
////////////////////////////////////////////////////////////////////////////
// I2C bit controller
// Prescaled four-phase engine for START, STOP and data bits on SCL/SDA
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module i2c_bit_ctrl import i2c_pkg::*; (
  input  logic        wb_clk_i,
  input  logic        arst_i,
  input  logic        en_i,
  input  logic [15:0] prescale_i,
  input  bit_req_t    bit_req_i,
  output logic        bit_done_o,
  output logic        bit_dout_o,
  input  logic        scl_pad_i,
  input  logic        sda_pad_i,
  output logic        scl_padoen_o,
  output logic        sda_padoen_o
);

  logic [1:0]  scl_sync;
  logic [1:0]  sda_sync;
  logic [15:0] pre_cnt;
  logic [1:0]  phase;
  logic        busy;
  bit_cmd_e    cmd_q;
  logic        din_q;
  logic        dout_q;
  logic        scl_oen;
  logic        sda_oen;
  logic        tick;
  logic        start;
  logic        load;
  bit_cmd_e    cmd_sel;
  logic        din_sel;
  logic [1:0]  phase_sel;
  logic        scl_nxt;
  logic        sda_nxt;

  assign tick       = en_i && busy && (pre_cnt == '0);
  assign start      = en_i && !busy && (bit_req_i.cmd != BIT_IDLE);
  assign load       = start || (tick && (phase != 2'd3));
  assign bit_done_o = tick && (phase == 2'd3);

  // Output enables for the phase about to begin
  always_comb begin
    cmd_sel   = busy ? cmd_q : bit_req_i.cmd;
    din_sel   = busy ? din_q : bit_req_i.din;
    phase_sel = busy ? phase + 2'd1 : 2'd0;
    scl_nxt   = scl_oen;
    sda_nxt   = sda_oen;
    case (cmd_sel)
      BIT_START: begin
        // SDA falls while SCL is high
        sda_nxt = (phase_sel < 2'd2);
        if (phase_sel != 2'd0) begin
          scl_nxt = (phase_sel != 2'd3);
        end
      end
      BIT_STOP: begin
        // SDA rises while SCL is high
        scl_nxt = (phase_sel != 2'd0);
        sda_nxt = (phase_sel == 2'd3);
      end
      BIT_WRITE, BIT_READ: begin
        scl_nxt = (phase_sel == 2'd1) || (phase_sel == 2'd2);
        sda_nxt = (cmd_sel == BIT_WRITE) ? din_sel : 1'b1;
      end
      default: begin
        scl_nxt = scl_oen;
        sda_nxt = sda_oen;
      end
    endcase
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
    end else begin
      scl_sync <= {scl_sync[0], scl_pad_i};
      sda_sync <= {sda_sync[0], sda_pad_i};
    end
  end

  always_ff @(posedge wb_clk_i or posedge arst_i) begin
    if (arst_i) begin
      busy    <= 1'b0;
      phase   <= 2'd0;
      pre_cnt <= '0;
      scl_oen <= 1'b1;
      sda_oen <= 1'b1;
    end else if (!en_i) begin
      busy    <= 1'b0;
      phase   <= 2'd0;
      pre_cnt <= '0;
      scl_oen <= 1'b1;
      sda_oen <= 1'b1;
    end else begin
      if (start) begin
        busy    <= 1'b1;
        phase   <= 2'd0;
        pre_cnt <= prescale_i;
      end else if (tick) begin
        pre_cnt <= prescale_i;
        if (phase == 2'd3) begin
          busy <= 1'b0;
        end else begin
          phase <= phase + 2'd1;
        end
      end else if (busy) begin
        pre_cnt <= pre_cnt - 16'd1;
      end
      if (load) begin
        scl_oen <= scl_nxt;
        sda_oen <= sda_nxt;
      end
    end
  end

  // Request is latched for the whole bit
  always_ff @(posedge wb_clk_i) begin
    if (start) begin
      cmd_q <= bit_req_i.cmd;
      din_q <= bit_req_i.din;
    end
    // Sample at the end of the SCL high phase
    if (tick && (phase == 2'd2) && scl_sync[1]) begin
      dout_q <= sda_sync[1];
    end
  end

  assign bit_dout_o   = dout_q;
  assign scl_padoen_o = scl_oen;
  assign sda_padoen_o = sda_oen;

endmodule

// File: rtl/i2c_master_top.sv
////////////////////////////////////////////////////////////////////////////
// I2C master controller top level
// Wishbone register block, byte sequencer and bit engine
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module i2c_master_top import i2c_pkg::*; (
  input  logic             wb_clk_i,
  input  logic             arst_i,
  input  logic [ADR_W-1:0] wb_adr_i,
  input  logic [DAT_W-1:0] wb_dat_i,
  input  logic             wb_we_i,
  input  logic             wb_stb_i,
  input  logic             wb_cyc_i,
  output logic [DAT_W-1:0] wb_dat_o,
  output logic             wb_ack_o,
  output logic             wb_inta_o,
  input  logic             scl_pad_i,
  input  logic             sda_pad_i,
  output logic             scl_pad_o,
  output logic             scl_padoen_o,
  output logic             sda_pad_o,
  output logic             sda_padoen_o
);

  logic [15:0] prescale;
  logic        en;
  byte_cmd_t   byte_cmd;
  byte_stat_t  byte_stat;
  bit_req_t    bit_req;
  logic        bit_done;
  logic        bit_dout;

  // Open drain lines pulled low only through the enables
  assign scl_pad_o = 1'b0;
  assign sda_pad_o = 1'b0;

  i2c_wb_regs u_regs (
    .wb_clk_i   (wb_clk_i),
    .arst_i     (arst_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_we_i    (wb_we_i),
    .wb_stb_i   (wb_stb_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .wb_inta_o  (wb_inta_o),
    .prescale_o (prescale),
    .en_o       (en),
    .cmd_o      (byte_cmd),
    .stat_i     (byte_stat)
  );

  i2c_byte_ctrl u_byte_ctrl (
    .wb_clk_i   (wb_clk_i),
    .arst_i     (arst_i),
    .en_i       (en),
    .cmd_i      (byte_cmd),
    .stat_o     (byte_stat),
    .bit_req_o  (bit_req),
    .bit_done_i (bit_done),
    .bit_dout_i (bit_dout)
  );

  i2c_bit_ctrl u_bit_ctrl (
    .wb_clk_i     (wb_clk_i),
    .arst_i       (arst_i),
    .en_i         (en),
    .prescale_i   (prescale),
    .bit_req_i    (bit_req),
    .bit_done_o   (bit_done),
    .bit_dout_o   (bit_dout),
    .scl_pad_i    (scl_pad_i),
    .sda_pad_i    (sda_pad_i),
    .scl_padoen_o (scl_padoen_o),
    .sda_padoen_o (sda_padoen_o)
  );

endmodule

// File: testbench/i2c_slave_model.sv
////////////////////////////////////////////////////////////////////////////
// Behavioural I2C slave model
// Acks its address and reads back the inverse of the last byte written
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module i2c_slave_model #(
  parameter logic [6:0] SLAVE_ADR = 7'h2A
) (
  input  logic scl_i,
  inout  wire  sda_io
);

  typedef enum logic [1:0] {S_IDLE, S_ADDR, S_WDATA, S_RDATA} slave_state_e;

  slave_state_e state = S_IDLE;
  logic         sda_low = 1'b0;
  logic [7:0]   shreg = '0;
  logic [7:0]   last_byte = '0;
  logic [7:0]   txd = '0;
  int           bit_cnt = 0;

  assign sda_io = sda_low ? 1'b0 : 1'bz;

  // START and STOP move SDA while SCL is high
  always @(negedge sda_io) begin
    if (scl_i === 1'b1) begin
      state   = S_ADDR;
      bit_cnt = 0;
      sda_low = 1'b0;
    end
  end

  always @(posedge sda_io) begin
    if (scl_i === 1'b1) begin
      state   = S_IDLE;
      sda_low = 1'b0;
    end
  end

  always @(posedge scl_i) begin
    case (state)
      S_ADDR, S_WDATA: begin
        if (bit_cnt < 8) begin
          shreg   = {shreg[6:0], sda_io};
          bit_cnt = bit_cnt + 1;
        end
      end
      S_RDATA: begin
        bit_cnt = bit_cnt + 1;
        // NACK from the master ends the read
        if (bit_cnt == 9) begin
          if (sda_io !== 1'b0) begin
            state = S_IDLE;
          end else begin
            bit_cnt = 0;
          end
        end
      end
      default: ;
    endcase
  end

  always @(negedge scl_i) begin
    case (state)
      S_ADDR, S_WDATA: begin
        if (bit_cnt == 8) begin
          if ((state == S_ADDR) && (shreg[7:1] != SLAVE_ADR)) begin
            state = S_IDLE;
          end else begin
            sda_low = 1'b1;
            bit_cnt = 9;
            if (state == S_WDATA) begin
              last_byte = shreg;
            end
          end
        end else if (bit_cnt == 9) begin
          sda_low = 1'b0;
          bit_cnt = 0;
          if (state == S_ADDR) begin
            if (shreg[0]) begin
              state   = S_RDATA;
              txd     = ~last_byte;
              sda_low = !txd[7];
            end else begin
              state = S_WDATA;
            end
          end
        end
      end
      S_RDATA: begin
        if (bit_cnt < 8) begin
          sda_low = !txd[7 - bit_cnt];
        end else begin
          sda_low = 1'b0;
        end
      end
      default: ;
    endcase
  end

endmodule

// File: testbench/tb_i2c_master.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the I2C master, register map and byte transfers
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_i2c_master import i2c_pkg::*; ();

  localparam logic [6:0] SLAVE_ADR = 7'h2A;
  localparam int NUM_BYTES = 10;
  localparam int PRE_MAX   = 5;
  localparam longint WATCHDOG_NS = 2 * NUM_BYTES * 9 * 4 * (PRE_MAX + 1) * 40 + 400 * 40;

  logic             wb_clk_i = 1'b0;
  logic             arst_i;
  logic [ADR_W-1:0] wb_adr_i;
  logic [DAT_W-1:0] wb_dat_i;
  logic             wb_we_i;
  logic             wb_stb_i;
  logic             wb_cyc_i;
  logic [DAT_W-1:0] wb_dat_o;
  logic             wb_ack_o;
  logic             wb_inta_o;
  logic             scl_pad_o;
  logic             scl_padoen_o;
  logic             sda_pad_o;
  logic             sda_padoen_o;
  tri1              scl_line;
  tri1              sda_line;

  logic [31:0]      lcg_state = 32'd51;
  logic [DAT_W-1:0] rd_data;
  logic [DAT_W-1:0] sr;
  logic [DAT_W-1:0] last_byte;
  logic [DAT_W-1:0] prer_lo;

  assign scl_line = scl_padoen_o ? 1'bz : scl_pad_o;
  assign sda_line = sda_padoen_o ? 1'bz : sda_pad_o;

  i2c_master_top dut (
    .wb_clk_i     (wb_clk_i),
    .arst_i       (arst_i),
    .wb_adr_i     (wb_adr_i),
    .wb_dat_i     (wb_dat_i),
    .wb_we_i      (wb_we_i),
    .wb_stb_i     (wb_stb_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_inta_o    (wb_inta_o),
    .scl_pad_i    (scl_line),
    .sda_pad_i    (sda_line),
    .scl_pad_o    (scl_pad_o),
    .scl_padoen_o (scl_padoen_o),
    .sda_pad_o    (sda_pad_o),
    .sda_padoen_o (sda_padoen_o)
  );

  i2c_slave_model #(.SLAVE_ADR(SLAVE_ADR)) u_slave (
    .scl_i  (scl_line),
    .sda_io (sda_line)
  );

  always #20 wb_clk_i = ~wb_clk_i;

  function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  // Expected SR after a finished transfer with TIP low
  function automatic logic [DAT_W-1:0] ref_sr(logic rxack, logic busy, logic iflag);
    logic [DAT_W-1:0] v;
    v           = '0;
    v[SR_RXACK] = rxack;
    v[SR_BUSY]  = busy;
    v[SR_IF]    = iflag;
    return v;
  endfunction

  function automatic logic ref_rxack(logic [6:0] adr);
    return adr != SLAVE_ADR;
  endfunction

  // Slave returns the inverse of the last data byte it took
  function automatic logic [DAT_W-1:0] ref_rx(logic [DAT_W-1:0] written);
    return ~written;
  endfunction

  task automatic abort_run(string why);
    $display("%s at %0t", why, $time);
    $display("FAIL: see errors above");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(string name, logic [DAT_W-1:0] got, logic [DAT_W-1:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %b expected %b", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "value mismatch");
    end
  endtask

  // Ack is a single-cycle pulse one cycle after the request is seen
  task automatic wb_access(logic [ADR_W-1:0] adr, logic we, logic [DAT_W-1:0] dat,
                           output logic [DAT_W-1:0] q);
    @(posedge wb_clk_i);
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_we_i  <= we;
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    @(posedge wb_clk_i);
    check_flag("wb_ack_o", wb_ack_o, 1'b0);
    @(posedge wb_clk_i);
    check_flag("wb_ack_o", wb_ack_o, 1'b1);
    q = wb_dat_o;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(logic [ADR_W-1:0] adr, logic [DAT_W-1:0] dat);
    logic [DAT_W-1:0] unused;
    wb_access(adr, 1'b1, dat, unused);
  endtask

  task automatic wb_read(logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] q);
    wb_access(adr, 1'b0, '0, q);
  endtask

  // Poll SR until TIP clears
  task automatic wait_xfer(output logic [DAT_W-1:0] status);
    int polls;
    polls = 0;
    do begin
      wb_read(REG_CR_SR, status);
      polls++;
      if (polls > 4000) begin
        abort_run("transfer never finished");
      end
    end while (status[SR_TIP]);
  endtask

  initial begin
    #(WATCHDOG_NS);
    abort_run("run timed out");
  end

  initial begin
    arst_i   <= 1'b1;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    wb_we_i  <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_cyc_i <= 1'b0;
    repeat (16) @(posedge wb_clk_i);
    arst_i <= 1'b0;

    // Reset values
    wb_read(REG_PRER_LO, rd_data);
    check_byte("PRER_LO", rd_data, 8'hFF);
    wb_read(REG_PRER_HI, rd_data);
    check_byte("PRER_HI", rd_data, 8'hFF);
    wb_read(REG_CTR, rd_data);
    check_byte("CTR", rd_data, 8'h00);
    wb_read(REG_CR_SR, rd_data);
    check_byte("SR", rd_data, 8'h00);
    wb_read(REG_TXR_RXR, rd_data);
    check_byte("RXR", rd_data, 8'h00);
    check_flag("wb_inta_o", wb_inta_o, 1'b0);
    check_flag("scl_padoen_o", scl_padoen_o, 1'b1);
    check_flag("sda_padoen_o", sda_padoen_o, 1'b1);
    check_flag("scl_pad_o", scl_pad_o, 1'b0);
    check_flag("sda_pad_o", sda_pad_o, 1'b0);

    // CTR masking and PRER lock while enabled
    wb_write(REG_CTR, 8'hFF);
    wb_read(REG_CTR, rd_data);
    check_byte("CTR", rd_data, 8'hC0);
    wb_write(REG_PRER_LO, 8'h12);
    wb_read(REG_PRER_LO, rd_data);
    check_byte("PRER_LO", rd_data, 8'hFF);
    wb_write(REG_CTR, 8'h00);
    prer_lo = (lcg_next() % (PRE_MAX - 1)) + 8'd2;
    wb_write(REG_PRER_LO, prer_lo);
    wb_write(REG_PRER_HI, 8'h00);
    wb_read(REG_PRER_LO, rd_data);
    check_byte("PRER_LO", rd_data, prer_lo);
    wb_read(REG_PRER_HI, rd_data);
    check_byte("PRER_HI", rd_data, 8'h00);
    wb_write(REG_CR_SR, 8'hFF);
    wb_read(REG_CR_SR, rd_data);
    check_byte("SR", rd_data, 8'h00);

    // Address write and random data bytes
    wb_write(REG_CTR, 8'h80);
    wb_write(REG_TXR_RXR, {SLAVE_ADR, 1'b0});
    wb_write(REG_CR_SR, 8'h90);
    wait_xfer(sr);
    check_byte("SR", sr, ref_sr(ref_rxack(SLAVE_ADR), 1'b1, 1'b1));
    repeat (4) begin
      last_byte = lcg_next();
      wb_write(REG_TXR_RXR, last_byte);
      wb_write(REG_CR_SR, 8'h10);
      wait_xfer(sr);
      check_byte("SR", sr, ref_sr(1'b0, 1'b1, 1'b1));
    end

    // Repeated START, read with NACK and STOP
    wb_write(REG_TXR_RXR, {SLAVE_ADR, 1'b1});
    wb_write(REG_CR_SR, 8'h90);
    wait_xfer(sr);
    check_byte("SR", sr, ref_sr(1'b0, 1'b1, 1'b1));
    wb_write(REG_CR_SR, 8'h68);
    wait_xfer(sr);
    check_byte("SR", sr, ref_sr(1'b0, 1'b0, 1'b1));
    wb_read(REG_TXR_RXR, rd_data);
    check_byte("RXR", rd_data, ref_rx(last_byte));

    // Wrong address is not acknowledged
    wb_write(REG_TXR_RXR, {SLAVE_ADR ^ 7'h11, 1'b0});
    wb_write(REG_CR_SR, 8'hD0);
    wait_xfer(sr);
    check_byte("SR", sr, ref_sr(ref_rxack(SLAVE_ADR ^ 7'h11), 1'b0, 1'b1));

    // Interrupt output
    wb_write(REG_CR_SR, 8'h01);
    repeat (3) @(posedge wb_clk_i);
    wb_write(REG_CTR, 8'hC0);
    repeat (2) @(posedge wb_clk_i);
    check_flag("wb_inta_o", wb_inta_o, 1'b0);
    wb_write(REG_TXR_RXR, {SLAVE_ADR, 1'b0});
    wb_write(REG_CR_SR, 8'h90);
    wait_xfer(sr);
    check_byte("SR", sr, ref_sr(1'b0, 1'b1, 1'b1));
    repeat (2) @(posedge wb_clk_i);
    check_flag("wb_inta_o", wb_inta_o, 1'b1);
    wb_write(REG_CR_SR, 8'h01);
    repeat (3) @(posedge wb_clk_i);
    check_flag("wb_inta_o", wb_inta_o, 1'b0);
    wb_read(REG_CR_SR, rd_data);
    check_flag("SR.IF", rd_data[SR_IF], 1'b0);
    wb_write(REG_CR_SR, 8'h40);
    wait_xfer(sr);
    check_flag("SR.BUSY", sr[SR_BUSY], 1'b0);

    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: all.f
rtl/i2c_pkg.sv
rtl/i2c_wb_regs.sv
rtl/i2c_byte_ctrl.sv
rtl/i2c_bit_ctrl.sv
rtl/i2c_master_top.sv
testbench/i2c_slave_model.sv
testbench/tb_i2c_master.sv

// File: Bender.yml
package:
  name: i2c_master

sources:
  - rtl/i2c_pkg.sv
  - rtl/i2c_wb_regs.sv
  - rtl/i2c_byte_ctrl.sv
  - rtl/i2c_bit_ctrl.sv
  - rtl/i2c_master_top.sv
  - target: simulation
    files:
      - testbench/i2c_slave_model.sv
      - testbench/tb_i2c_master.sv
